// File: hdl/cart_loader_pkg.sv
// Byte addresses of 16-bit words, low byte at the even address; cheat files use index 0xFF
`default_nettype none

package cart_loader_pkg;

	localparam int ADDR_W = 25; // Download byte address
	localparam int DATA_W = 16; // Download word

	// Header words
	localparam logic [ADDR_W-1:0] HDR_REGION_ADDR  = 'h1F0;
	localparam logic [ADDR_W-1:0] HDR_REGION2_ADDR = 'h1F2;
	localparam logic [ADDR_W-1:0] HDR_END_ADDR     = 'h200;

	// Cartridge ID, checksum and the word that triggers the lookup
	localparam logic [ADDR_W-1:0] ID_BASE_ADDR   = 'h180;
	localparam logic [ADDR_W-1:0] ID_CRC_ADDR    = 'h18E;
	localparam logic [ADDR_W-1:0] ID_DECODE_ADDR = 'h190;

	localparam logic [ADDR_W-1:0] RT_ID_ADDR = 'h7E100; // Decoded at the third word

	localparam logic [7:0] CODE_INDEX        = 8'hFF;
	localparam logic [7:0] DEFAULT_GUN_DELAY = 8'd44; // Sensor delay without a table hit

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} dl_beat_t;

	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} region_flags_t;

	typedef struct packed {
		logic [2:0] eeprom_map;
		logic       bank_eeprom;
		logic       realtec_map;
		logic       noram;
		logic       pier;
		logic       svp;
		logic       fmbusy;
		logic       schan;
		logic [2:0] sf_map;
		logic       gun_type;
		logic [7:0] gun_delay;
	} cart_quirks_t;

	////////////////////////////////////////////////////////////////////////////
	// Cartridge ID, 11 characters, first character in the top byte

	typedef struct packed {
		logic [23:0] prefix; // "GM " and the like
		logic [63:0] serial;
	} cart_serial_t;

	typedef struct packed {
		logic [47:0] maker; // Unlicensed SF-00x titles
		logic [39:0] rest;
	} cart_maker_t;

	typedef union packed {
		cart_serial_t ser;
		cart_maker_t  mk;
	} cart_id_u;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

// File: hdl/dl_stream_tracker.sv
// Writes count only while ioctl_download is high; ioctl_index must hold for the whole download
`timescale 1ns/1ns
`default_nettype none

module dl_stream_tracker import cart_loader_pkg::*; (
	input  wire               clk_sys,
	input  wire               RESET,
	input  wire               ioctl_download,
	input  wire  [7:0]        ioctl_index,
	input  wire               ioctl_wr,
	input  wire  [ADDR_W-1:0] ioctl_addr,
	input  wire  [DATA_W-1:0] ioctl_data,
	output dl_beat_t          cart_beat,
	output dl_beat_t          code_beat,
	output logic              cart_start,
	output logic              cart_end,
	output logic              cart_loading,
	output logic [ADDR_W-1:0] rom_sz
);

	logic              code_sel;
	logic              cart_loading_q;
	logic [ADDR_W-1:0] last_addr;

	assign code_sel     = (ioctl_index == CODE_INDEX);
	assign cart_loading = ioctl_download & ~code_sel;

	assign cart_beat = '{valid: cart_loading & ioctl_wr, addr: ioctl_addr, data: ioctl_data};
	assign code_beat = '{valid: ioctl_download & code_sel & ioctl_wr, addr: ioctl_addr,
		data: ioctl_data};

	// Edges of the cartridge download
	assign cart_start = cart_loading & ~cart_loading_q;
	assign cart_end   = cart_loading_q & ~cart_loading;

	always_ff @(posedge clk_sys) begin
		if (RESET) cart_loading_q <= 1'b0;
		else cart_loading_q <= cart_loading;
	end

	always_ff @(posedge clk_sys) begin
		if (cart_beat.valid) last_addr <= ioctl_addr; // Last word actually written
		if (cart_end) rom_sz <= last_addr;
	end

endmodule

`default_nettype wire

// File: hdl/header_region_parser.sv
// Region codes at 0x1F0/0x1F2 only; flags hold from the header until the next download starts
`timescale 1ns/1ns
`default_nettype none

module header_region_parser import cart_loader_pkg::*; (
	input  wire           clk_sys,
	input  wire           RESET,
	input  dl_beat_t      cart_beat,
	input  wire           cart_start,
	input  wire           cart_end,
	output region_flags_t region_flags,
	output logic          hdr_ready
);

	logic [7:0]    lo_ch;
	logic [7:0]    hi_ch;
	logic [3:0]    hex_nib;
	region_flags_t flags_nxt;

	// A single letter J, U or E adds its flag
	function automatic region_flags_t letter_flags(input logic [7:0] ch, input region_flags_t cur);
		region_flags_t f;
		f = cur;
		case (ch)
			"J": f.j = 1'b1;
			"U": f.u = 1'b1;
			"E": f.e = 1'b1;
			default: ;
		endcase
		return f;
	endfunction

	assign lo_ch   = cart_beat.data[7:0]; // Even address byte
	assign hi_ch   = cart_beat.data[15:8];
	assign hex_nib = lo_ch[3:0] - 4'd7;   // 'A'..'F' low nibble to 0xA..0xF

	always_comb begin
		flags_nxt = region_flags;
		if (cart_beat.addr == HDR_REGION_ADDR) begin
			if (lo_ch inside {"J", "U", "E"}) begin
				flags_nxt = letter_flags(lo_ch, flags_nxt);
			end else if (lo_ch >= "0" && lo_ch <= "9") begin
				flags_nxt = '{j: lo_ch[0], u: lo_ch[2], e: lo_ch[3]}; // New style bit code
			end else if (lo_ch >= "A" && lo_ch <= "F") begin
				flags_nxt = '{j: hex_nib[0], u: hex_nib[2], e: hex_nib[3]};
			end
			flags_nxt = letter_flags(hi_ch, flags_nxt);
		end else if (cart_beat.addr == HDR_REGION2_ADDR) begin
			flags_nxt = letter_flags(lo_ch, flags_nxt);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET || cart_start) region_flags <= '0;
		else if (cart_beat.valid) region_flags <= flags_nxt;

		// Header is complete once the download passes 0x200
		if (RESET || cart_end) hdr_ready <= 1'b0;
		else if (cart_beat.valid && cart_beat.addr == HDR_END_ADDR) hdr_ready <= 1'b1;
	end

endmodule

`default_nettype wire

// File: hdl/region_selector.sv
// Region is picked once per header; region_set stays high until hdr_ready falls
`timescale 1ns/1ns
`default_nettype none

module region_selector import cart_loader_pkg::*; (
	input  wire           clk_sys,
	input  wire           RESET,
	input  region_flags_t region_flags,
	input  wire           hdr_ready,
	input  wire           auto_region_off,
	input  wire  [1:0]    region_priority,
	output region_e       region_req,
	output logic          region_set
);

	logic hdr_ready_q;

	// First present region in the chosen order
	function automatic region_e pick_region(input region_flags_t f, input logic [1:0] prio);
		region_e    order [3];
		logic [2:0] present;
		region_e    pick;
		present = {f.e, f.u, f.j}; // Bit index is the region code
		case (prio)
			2'd0: order = '{REGION_US, REGION_EU, REGION_JP};
			2'd1: order = '{REGION_EU, REGION_US, REGION_JP};
			2'd2: order = '{REGION_US, REGION_JP, REGION_EU};
			default: order = '{REGION_JP, REGION_US, REGION_EU};
		endcase
		pick = order[0]; // No flag at all
		for (int i = 2; i >= 0; i--) begin
			if (present[order[i]]) pick = order[i];
		end
		return pick;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Request on the rising edge of hdr_ready, release on its falling edge

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_ready_q <= 1'b0;
			region_set  <= 1'b0;
			region_req  <= REGION_JP;
		end else begin
			hdr_ready_q <= hdr_ready;
			if (hdr_ready && !hdr_ready_q && !auto_region_off) begin
				region_set <= 1'b1;
				region_req <= pick_region(region_flags, region_priority);
			end else if (!hdr_ready && hdr_ready_q) begin
				region_set <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/cart_quirk_table.sv
// Lookup fires on the word at 0x190, so the ID words must arrive before it; gun falls back to default
`timescale 1ns/1ns
`default_nettype none

module cart_quirk_table import cart_loader_pkg::*; #(
	parameter logic [7:0] DEFAULT_GUN_DELAY_P = DEFAULT_GUN_DELAY
) (
	input  wire          clk_sys,
	input  wire          RESET,
	input  dl_beat_t     cart_beat,
	input  wire          cart_start,
	output cart_quirks_t quirks
);

	localparam cart_quirks_t QUIRKS_IDLE = '{gun_delay: DEFAULT_GUN_DELAY_P, default: '0};

	logic [87:0]       id_raw;
	cart_id_u          cart_id;
	logic [15:0]       crc;
	logic [31:0]       rt_id;  // Second-format ID
	logic [15:0]       swp;
	logic [ADDR_W-1:0] id_off;
	logic [ADDR_W-1:0] rt_off;
	cart_quirks_t      id_quirks;

	function automatic logic [15:0] swap16(input logic [15:0] w);
		return {w[7:0], w[15:8]};
	endfunction

	assign swp     = swap16(cart_beat.data); // Text reads big endian
	assign id_off  = cart_beat.addr - ID_BASE_ADDR;
	assign rt_off  = cart_beat.addr - RT_ID_ADDR;
	assign cart_id = id_raw;

	always_ff @(posedge clk_sys) begin
		if (cart_beat.valid) begin
			case (id_off)
				ADDR_W'(0):  id_raw[87:72] <= swp;
				ADDR_W'(2):  id_raw[71:56] <= swp;
				ADDR_W'(4):  id_raw[55:40] <= swp;
				ADDR_W'(6):  id_raw[39:24] <= swp;
				ADDR_W'(8):  id_raw[23:8]  <= swp;
				ADDR_W'(10): id_raw[7:0]   <= swp[15:8]; // 11th character only
				default: ;
			endcase
			if (cart_beat.addr == ID_CRC_ADDR) crc <= swp;
			if (rt_off == ADDR_W'(0)) rt_id[31:16] <= swp;
			if (rt_off == ADDR_W'(2)) rt_id[15:0] <= swp;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Serial and maker table

	always_comb begin
		id_quirks = quirks;
		case (cart_id.ser.serial)
			"T-081276", "T-81406 ", "T-081586": id_quirks.bank_eeprom = 1'b1; // Acclaim boards
			"T-50446 ", "T-50396 ", "T-50176 ": id_quirks.eeprom_map = 3'b001; // EA
			"MK-1215 ", "G-4060  ", "T-12046 ": id_quirks.eeprom_map = 3'b010; // Sega/Capcom
			"T-81033 ", "T-081326": id_quirks.eeprom_map = 3'b011;
			"T-113016": id_quirks.noram = 1'b1;  // Fake RAM check
			"T-574023", "T-574013": id_quirks.pier = 1'b1;
			"MK-1229 ", "G-7001  ": id_quirks.svp = 1'b1;
			"T-35036 ", "T-25073 ": id_quirks.fmbusy = 1'b1;
			"T-68???-": id_quirks.schan = 1'b1;
			default: begin
				if (cart_id.mk.maker == "SF-001") id_quirks.sf_map = {crc == 16'h3E08, 2'b01};
				else if (cart_id.mk.maker == "SF-002") id_quirks.sf_map = 3'b110;
				else if (cart_id.mk.maker == "SF-004") id_quirks.sf_map = 3'b111;
			end
		endcase

		// Light gun type and sensor timing
		case (cart_id.ser.serial)
			"MK-1533 ": {id_quirks.gun_type, id_quirks.gun_delay} = {1'b0, 8'd100};
			"T-95096-": {id_quirks.gun_type, id_quirks.gun_delay} = {1'b1, 8'd52};
			"T-95136-": {id_quirks.gun_type, id_quirks.gun_delay} = {1'b1, 8'd30};
			"MK-1658 ": {id_quirks.gun_type, id_quirks.gun_delay} = {1'b0, 8'd120};
			"T-081156": {id_quirks.gun_type, id_quirks.gun_delay} = {1'b0, 8'd126};
			default: {id_quirks.gun_type, id_quirks.gun_delay} = {1'b0, DEFAULT_GUN_DELAY_P};
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET || cart_start) begin
			quirks <= QUIRKS_IDLE;
		end else if (cart_beat.valid) begin
			if (cart_beat.addr == ID_DECODE_ADDR) quirks <= id_quirks;
			if (rt_off == ADDR_W'(4) && rt_id == "SEGA") quirks.realtec_map <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/cheat_code_loader.sv
// Words land by addr[3:0] only, 16 bytes per code; flags word must come first in each code
`timescale 1ns/1ns
`default_nettype none

module cheat_code_loader import cart_loader_pkg::*; (
	input  wire         clk_sys,
	input  wire         RESET,
	input  dl_beat_t    code_beat,
	output cheat_code_t code,
	output logic        cheat_strobe,
	output logic        cheat_clear
);

	logic [3:0] offset;

	assign offset = code_beat.addr[3:0];

	// Low word first for each 32-bit field
	always_ff @(posedge clk_sys) begin
		if (code_beat.valid) begin
			case (offset)
				4'd0:  code.flags[15:0]    <= code_beat.data;
				4'd2:  code.flags[31:16]   <= code_beat.data;
				4'd4:  code.addr[15:0]     <= code_beat.data;
				4'd6:  code.addr[31:16]    <= code_beat.data;
				4'd8:  code.compare[15:0]  <= code_beat.data;
				4'd10: code.compare[31:16] <= code_beat.data;
				4'd12: code.replace[15:0]  <= code_beat.data;
				4'd14: code.replace[31:16] <= code_beat.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_strobe <= 1'b0;
			cheat_clear  <= 1'b0;
		end else begin
			// Address bit 31 marks a disabled code
			cheat_strobe <= code_beat.valid && offset == 4'd14 && !code.addr[31];
			cheat_clear  <= code_beat.valid && offset == 4'd0;
		end
	end

endmodule

`default_nettype wire

// File: hdl/cart_loader_top.sv
// Every ioctl_wr is taken; no wait output, so the host must pace writes itself
`timescale 1ns/1ns
`default_nettype none

module cart_loader_top import cart_loader_pkg::*; #(
	parameter logic [7:0] DEFAULT_GUN_DELAY_P = DEFAULT_GUN_DELAY
) (
	input  wire               clk_sys,
	input  wire               RESET,
	input  wire               ioctl_download,
	input  wire  [7:0]        ioctl_index,
	input  wire               ioctl_wr,
	input  wire  [ADDR_W-1:0] ioctl_addr,
	input  wire  [DATA_W-1:0] ioctl_data,
	input  wire               auto_region_off, // Keep the menu region
	input  wire  [1:0]        region_priority,
	output logic [ADDR_W-1:0] rom_sz,
	output region_e           region_req,
	output logic              region_set,
	output cart_quirks_t      quirks,
	output cheat_code_t       code,
	output logic              cheat_strobe,
	output logic              cheat_clear,
	output logic              cart_loading
);

	dl_beat_t      cart_beat;
	dl_beat_t      code_beat;
	logic          cart_start;
	logic          cart_end;
	region_flags_t region_flags;
	logic          hdr_ready;

	////////////////////////////////////////////////////////////////////////////
	// Download stream

	dl_stream_tracker i_dl_stream_tracker (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.cart_beat      (cart_beat),
		.code_beat      (code_beat),
		.cart_start     (cart_start),
		.cart_end       (cart_end),
		.cart_loading   (cart_loading),
		.rom_sz         (rom_sz)
	);

	// Header region
	header_region_parser i_header_region_parser (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_beat    (cart_beat),
		.cart_start   (cart_start),
		.cart_end     (cart_end),
		.region_flags (region_flags),
		.hdr_ready    (hdr_ready)
	);

	region_selector i_region_selector (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.region_flags    (region_flags),
		.hdr_ready       (hdr_ready),
		.auto_region_off (auto_region_off),
		.region_priority (region_priority),
		.region_req      (region_req),
		.region_set      (region_set)
	);

	cart_quirk_table #(
		.DEFAULT_GUN_DELAY_P (DEFAULT_GUN_DELAY_P)
	) i_cart_quirk_table (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_beat  (cart_beat),
		.cart_start (cart_start),
		.quirks     (quirks)
	);

	cheat_code_loader i_cheat_code_loader (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.code_beat    (code_beat),
		.code         (code),
		.cheat_strobe (cheat_strobe),
		.cheat_clear  (cheat_clear)
	);

endmodule

`default_nettype wire

// File: verif/tb_cart_loader_ref.svh
// Expected region, quirks and cheat codes from the header, table and offset rules; no timing
`ifndef TB_CART_LOADER_REF_SVH
`define TB_CART_LOADER_REF_SVH

function automatic region_flags_t add_letter(input logic [7:0] ch, input region_flags_t f);
	region_flags_t r;
	r = f;
	if (ch == "J") r.j = 1'b1;
	if (ch == "U") r.u = 1'b1;
	if (ch == "E") r.e = 1'b1;
	return r;
endfunction

// Region flags from the low and high byte at 0x1F0 and the low byte at 0x1F2
function automatic region_flags_t ref_flags(input logic [7:0] lo0, input logic [7:0] hi0,
	input logic [7:0] lo2);
	region_flags_t f;
	logic [7:0]    v;
	f = '0;
	v = 8'd0;
	if (lo0 == "J" || lo0 == "U" || lo0 == "E") f = add_letter(lo0, f);
	else if (lo0 >= "0" && lo0 <= "9") v = lo0 - 8'h30;
	else if (lo0 >= "A" && lo0 <= "F") v = lo0 - 8'h41 + 8'd10;
	f.e = f.e | v[3]; // Bit code, e u - j
	f.u = f.u | v[2];
	f.j = f.j | v[0];
	f = add_letter(hi0, f);
	f = add_letter(lo2, f);
	return f;
endfunction

function automatic region_e ref_region(input region_flags_t f, input logic [1:0] prio);
	case (prio)
		2'd0: return f.u ? REGION_US : f.e ? REGION_EU : f.j ? REGION_JP : REGION_US;
		2'd1: return f.e ? REGION_EU : f.u ? REGION_US : f.j ? REGION_JP : REGION_EU;
		2'd2: return f.u ? REGION_US : f.j ? REGION_JP : f.e ? REGION_EU : REGION_US;
		default: return f.j ? REGION_JP : f.u ? REGION_US : f.e ? REGION_EU : REGION_JP;
	endcase
endfunction

// Quirks of the games that the test uses; maker prefix only when the serial is unknown
function automatic cart_quirks_t ref_quirks(input logic [87:0] id, input logic [15:0] crc,
	input logic sega_rt);
	cart_quirks_t q;
	logic [63:0]  s;
	logic [47:0]  m;
	q = '0;
	q.gun_delay = GUN_DELAY;
	s = id[63:0];
	m = id[87:40];
	if (s == "T-081276") q.bank_eeprom = 1'b1;
	else if (s == "T-50446 ") q.eeprom_map = 3'd1;
	else if (s == "MK-1215 ") q.eeprom_map = 3'd2;
	else if (s == "T-81033 ") q.eeprom_map = 3'd3;
	else if (s == "T-113016") q.noram = 1'b1;
	else if (s == "T-574023") q.pier = 1'b1;
	else if (s == "MK-1229 ") q.svp = 1'b1;
	else if (s == "T-35036 ") q.fmbusy = 1'b1;
	else if (s == "T-68???-") q.schan = 1'b1;
	else if (m == "SF-001") q.sf_map = (crc == 16'h3E08) ? 3'b101 : 3'b001;
	else if (m == "SF-002") q.sf_map = 3'b110;
	else if (m == "SF-004") q.sf_map = 3'b111;
	if (s == "MK-1533 ") q.gun_delay = 8'd100;
	if (s == "T-95096-") begin
		q.gun_type  = 1'b1;
		q.gun_delay = 8'd52;
	end
	q.realtec_map = sega_rt;
	return q;
endfunction

// Word k sits at byte offset 2k, low half of each field first
function automatic cheat_code_t ref_cheat(input logic [7:0][15:0] w);
	cheat_code_t c;
	c.flags   = {w[1], w[0]};
	c.addr    = {w[3], w[2]};
	c.compare = {w[5], w[4]};
	c.replace = {w[7], w[6]};
	return c;
endfunction

`endif

// File: verif/tb_cart_loader.sv
// Checks outputs every falling edge against expected values; stops after 20000 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_cart_loader import cart_loader_pkg::*; ();

	localparam logic [7:0] GUN_DELAY = 8'd37; // Sensor delay without a table hit

	`include "tb_cart_loader_ref.svh"

	localparam int TIMEOUT_CYCLES = 20000; // About 60 downloads of under 40 cycles, with margin

	logic              clk_sys;
	logic              RESET;
	logic              ioctl_download;
	logic [7:0]        ioctl_index;
	logic              ioctl_wr;
	logic [ADDR_W-1:0] ioctl_addr;
	logic [DATA_W-1:0] ioctl_data;
	logic              auto_region_off;
	logic [1:0]        region_priority;
	logic [ADDR_W-1:0] rom_sz;
	region_e           region_req;
	logic              region_set;
	cart_quirks_t      quirks;
	cheat_code_t       code;
	logic              cheat_strobe;
	logic              cheat_clear;
	logic              cart_loading;

	// Expected state, updated by the stimulus right after the DUT edge
	cart_quirks_t      exp_quirks;
	logic              exp_region_set;
	region_e           exp_region_req;
	logic [ADDR_W-1:0] exp_rom_sz;
	cheat_code_t       exp_code;
	logic              exp_loading;
	logic              chk_en;
	logic              rom_chk;
	int                n_strobe;
	int                n_clear;
	int                exp_strobe;
	int                exp_clear;
	int                errors;
	int                checks;
	int                tests;
	int                test_err0;
	int                cycles;
	logic [87:0]       qid [15];
	logic [15:0]       qcrc [15];

	cart_loader_top #(
		.DEFAULT_GUN_DELAY_P (GUN_DELAY)
	) i_cart_loader_top (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.ioctl_download  (ioctl_download),
		.ioctl_index     (ioctl_index),
		.ioctl_wr        (ioctl_wr),
		.ioctl_addr      (ioctl_addr),
		.ioctl_data      (ioctl_data),
		.auto_region_off (auto_region_off),
		.region_priority (region_priority),
		.rom_sz          (rom_sz),
		.region_req      (region_req),
		.region_set      (region_set),
		.quirks          (quirks),
		.code            (code),
		.cheat_strobe    (cheat_strobe),
		.cheat_clear     (cheat_clear),
		.cart_loading    (cart_loading)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic report_error(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		errors++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare process, mid-cycle where registered outputs are stable

	always @(negedge clk_sys) begin
		if (chk_en) begin
			checks++;
			if (quirks !== exp_quirks) report_error($sformatf("quirks %h, expected %h",
				quirks, exp_quirks));
			if (region_set !== exp_region_set) report_error($sformatf("region_set %b",
				region_set));
			if (region_req !== exp_region_req) report_error($sformatf("region_req %0d, expected %0d",
				region_req, exp_region_req));
			if (rom_chk && rom_sz !== exp_rom_sz) report_error($sformatf("rom_sz %h, expected %h",
				rom_sz, exp_rom_sz));
			if (cart_loading !== exp_loading) report_error($sformatf("cart_loading %b, expected %b",
				cart_loading, exp_loading));
			if (cheat_strobe) begin
				n_strobe++;
				if (code !== exp_code) report_error($sformatf("code %h, expected %h",
					code, exp_code));
			end
			if (cheat_clear) n_clear++;
		end
	end

	task automatic write_word(input logic [ADDR_W-1:0] a, input logic [15:0] d);
		ioctl_wr   = 1'b1;
		ioctl_addr = a;
		ioctl_data = d;
		@(posedge clk_sys);
		#1;
		ioctl_wr = 1'b0;
	endtask

	// Cartridge image: ID, checksum, header region, end word, second-format ID, last word
	task automatic stream_cart(input logic [87:0] id, input logic [15:0] crc,
		input logic [7:0] lo0, input logic [7:0] hi0, input logic [7:0] lo2,
		input logic [31:0] rt, input logic [ADDR_W-1:0] last);
		logic [95:0] idp;
		idp = {id, 8'h20};
		ioctl_index    = 8'h00;
		ioctl_download = 1'b1;
		exp_loading    = 1'b1;
		@(posedge clk_sys);
		#1;
		exp_quirks = ref_quirks(88'h0, 16'h0, 1'b0); // Cleared by the start pulse
		for (int i = 0; i < 6; i++) begin
			write_word(ID_BASE_ADDR + ADDR_W'(2 * i), {idp[87-16*i -: 8], idp[95-16*i -: 8]});
		end
		write_word(ADDR_W'('h18C), 16'($urandom));
		write_word(ID_CRC_ADDR, {crc[7:0], crc[15:8]});
		write_word(ID_DECODE_ADDR, 16'($urandom));
		exp_quirks = ref_quirks(id, crc, 1'b0);
		write_word(HDR_REGION_ADDR, {hi0, lo0});
		write_word(HDR_REGION2_ADDR, {8'($urandom), lo2});
		write_word(HDR_END_ADDR, 16'($urandom));
		@(posedge clk_sys);
		#1;
		if (!auto_region_off) begin
			exp_region_set = 1'b1;
			exp_region_req = ref_region(ref_flags(lo0, hi0, lo2), region_priority);
		end
		write_word(RT_ID_ADDR, {rt[23:16], rt[31:24]});
		write_word(RT_ID_ADDR + ADDR_W'(2), {rt[7:0], rt[15:8]});
		write_word(RT_ID_ADDR + ADDR_W'(4), 16'($urandom));
		exp_quirks = ref_quirks(id, crc, rt == "SEGA");
		write_word(last, 16'($urandom));
		ioctl_download = 1'b0;
		exp_loading    = 1'b0;
		@(posedge clk_sys);
		#1;
		exp_rom_sz = last;
		rom_chk    = 1'b1;
		@(posedge clk_sys);
		#1;
		exp_region_set = 1'b0;
	endtask

	// One cheat file with a single 16-byte code at the given base
	task automatic stream_cheat(input logic [7:0][15:0] w, input logic [ADDR_W-1:0] base);
		exp_code = ref_cheat(w);
		if (!w[3][15]) exp_strobe++; // Address bit 31 disables the code
		exp_clear++;
		ioctl_index    = CODE_INDEX;
		ioctl_download = 1'b1;
		@(posedge clk_sys);
		#1;
		for (int k = 0; k < 8; k++) write_word(base + ADDR_W'(2 * k), w[k]);
		ioctl_download = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_err0) $display("test %0d %s: ok", tests, name);
		else $display("test %0d %s: %0d errors", tests, name, errors - test_err0);
		test_err0 = errors;
	endtask

	function automatic logic [7:0] random_letter();
		case ($urandom % 5)
			0: return "J";
			1: return "U";
			2: return "E";
			default: return " ";
		endcase
	endfunction

	function automatic logic [ADDR_W-1:0] random_last();
		return ADDR_W'('h1000) + ADDR_W'($urandom & 32'hFFE);
	endfunction

	initial begin
		logic [7:0][15:0] w;
		logic [7:0]       ch;
		void'($urandom(88743));
		RESET           = 1'b1;
		ioctl_download  = 1'b0;
		ioctl_wr        = 1'b0;
		auto_region_off = 1'b0;
		chk_en          = 1'b0;
		rom_chk         = 1'b0;
		ioctl_index     = 8'h00;
		ioctl_addr      = '0;
		ioctl_data      = '0;
		region_priority = 2'd0;
		exp_quirks      = ref_quirks(88'h0, 16'h0, 1'b0);
		exp_region_set  = 1'b0;
		exp_region_req  = REGION_JP;
		exp_rom_sz      = '0;
		exp_code        = '0;
		exp_loading     = 1'b0;
		n_strobe        = 0;
		n_clear         = 0;
		exp_strobe      = 0;
		exp_clear       = 0;
		errors          = 0;
		checks          = 0;
		tests           = 0;
		test_err0       = 0;
		qid = '{"GM T-081276", "GM T-50446 ", "GM MK-1215 ", "GM T-81033 ", "GM T-113016",
			"GM T-574023", "GM MK-1229 ", "GM T-35036 ", "GM T-68???-", "GM MK-1533 ",
			"GM T-95096-", "GM T-99999 ", "SF-001 ABCD", "SF-001 ABCD", "SF-004 ABCD"};
		qcrc = '{default: 16'h1234};
		qcrc[12] = 16'h3E08;
		repeat (10) @(posedge clk_sys);
		#1;
		RESET  = 1'b0;
		chk_en = 1'b1;

		for (int p = 0; p < 4; p++) begin
			region_priority = 2'(p);
			for (int n = 0; n < 4; n++) begin
				stream_cart("GM T-99999 ", 16'h0, random_letter(), random_letter(),
					random_letter(), "NONE", random_last());
			end
		end
		end_test("region priority");

		region_priority = 2'(3);
		for (int d = 0; d < 16; d++) begin
			ch = (d < 10) ? 8'h30 + 8'(d) : 8'h41 + 8'(d - 10); // '0'..'9', 'A'..'F'
			stream_cart("GM T-99999 ", 16'h0, ch, " ", " ", "NONE", random_last());
		end
		auto_region_off = 1'b1;
		stream_cart("GM T-99999 ", 16'h0, "E", "U", "J", "NONE", random_last());
		auto_region_off = 1'b0;
		end_test("region bit codes");

		for (int q = 0; q < 15; q++) stream_cart(qid[q], qcrc[q], "U", " ", " ", "NONE",
			random_last());
		stream_cart("SF-002 ABCD", 16'h0, "J", " ", " ", "NONE", random_last());
		stream_cart("GM T-99999 ", 16'h0, "J", " ", " ", "SEGA", random_last());
		stream_cart("GM T-99999 ", 16'h0, "J", " ", " ", "NONE", random_last());
		end_test("quirk table");

		for (int c = 0; c < 12; c++) begin
			for (int k = 0; k < 8; k++) w[k] = 16'($urandom);
			w[3][15] = (c % 4 == 3);
			stream_cheat(w, ADDR_W'(16 * c));
		end
		if (n_strobe != exp_strobe) report_error($sformatf("%0d cheat strobes, expected %0d",
			n_strobe, exp_strobe));
		if (n_clear != exp_clear) report_error($sformatf("%0d cheat clears, expected %0d",
			n_clear, exp_clear));
		end_test("cheat codes");

		stream_cart("GM T-35036 ", 16'h0, "E", " ", " ", "NONE", ADDR_W'('h1FFFE));
		for (int k = 0; k < 8; k++) w[k] = 16'($urandom);
		stream_cheat(w, ADDR_W'('h40));
		if (rom_sz !== ADDR_W'('h1FFFE)) report_error("rom_sz changed by cheat download");
		end_test("rom size");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) $display("PASS: all tests");
		else $display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+verif
hdl/cart_loader_pkg.sv
hdl/dl_stream_tracker.sv
hdl/header_region_parser.sv
hdl/region_selector.sv
hdl/cart_quirk_table.sv
hdl/cheat_code_loader.sv
hdl/cart_loader_top.sv
verif/tb_cart_loader.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --timing
TOP        = tb_cart_loader
FILELIST   = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) verif/tb_cart_loader_ref.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "PASS: all tests" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
